/* common/lc3b_pkg.sv */
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Opcode field, ir[15:12].
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not
	} alu_op_t;

	// Control word built in decode and carried to writeback.
	typedef struct packed {
		alu_op_t alu_op;
		logic    imm_sel;      // Operand B is imm5.
		logic    addr_sel;     // Result is base plus offset6.
		logic    load_regfile;
		logic    mem_read;
		logic    mem_write;
		lc3b_reg dest;
	} ctrl_t;

	typedef struct packed {
		logic     valid;
		lc3b_word pc;
		lc3b_word ir;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		lc3b_word pc;
		lc3b_word ir;
		ctrl_t    ctrl;
		lc3b_word sr1;
		lc3b_word sr2;   // Store source for STR.
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		lc3b_word pc;
		lc3b_word ir;
		ctrl_t    ctrl;
		lc3b_word alu;
		lc3b_word store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		lc3b_word pc;
		lc3b_word ir;
		ctrl_t    ctrl;
		lc3b_word alu;
		lc3b_word mdr;
	} wb_t;

	localparam lc3b_word pc_reset = 16'h0000;

endpackage : lc3b_pkg

/* rtl/pipe_latch.sv */
`timescale 1ns/1ps

// Stage register between two pipeline stages.
// An all-zero payload is a bubble since its valid bit is clear.
module pipe_latch #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;  // Bubble.
		end else begin
			q <= d;   // No stalls, loads every cycle.
		end
	end

endmodule : pipe_latch

/* fetch/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch (
	input  logic              clk,
	input  logic              arst_n,
	output lc3b_pkg::lc3b_word pc,
	output logic              fetch_en
);

	assign fetch_en = arst_n;  // Fetch runs whenever out of reset.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= lc3b_pkg::pc_reset;
		end else begin
			pc <= pc + 16'd2;  // Next sequential word.
		end
	end

endmodule : instruction_fetch

/* decode/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               arst_n,
	input  lc3b_pkg::wb_t      wb,
	input  lc3b_pkg::lc3b_reg  rd_a,
	input  lc3b_pkg::lc3b_reg  rd_b,
	output lc3b_pkg::lc3b_word a,
	output lc3b_pkg::lc3b_word b
);

	lc3b_pkg::lc3b_word regs [8];
	lc3b_pkg::lc3b_word wr_data;
	logic               wr_en;

	assign wr_en   = wb.valid && wb.ctrl.load_regfile;
	assign wr_data = wb.ctrl.mem_read ? wb.mdr : wb.alu;  // Loads write the MDR.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.ctrl.dest] <= wr_data;
		end
	end

	// Write-through: a same-cycle read of the destination sees the new value.
	assign a = (wr_en && (wb.ctrl.dest == rd_a)) ? wr_data : regs[rd_a];
	assign b = (wr_en && (wb.ctrl.dest == rd_b)) ? wr_data : regs[rd_b];

endmodule : regfile

/* decode/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode (
	input  logic               clk,
	input  logic               arst_n,
	input  lc3b_pkg::if_id_t   if_id,
	input  lc3b_pkg::wb_t      wb,
	output lc3b_pkg::id_ex_t   id_ex
);

	lc3b_pkg::lc3b_opcode opcode;
	lc3b_pkg::lc3b_reg    sr1_num;
	lc3b_pkg::lc3b_reg    sr2_num;
	lc3b_pkg::lc3b_word   sr1_val;
	lc3b_pkg::lc3b_word   sr2_val;
	lc3b_pkg::ctrl_t      ctrl;

	assign opcode  = lc3b_pkg::lc3b_opcode'(if_id.ir[15:12]);
	assign sr1_num = if_id.ir[8:6];  // SR1, or base register for LDR/STR.

	// STR reads its store source from the destination field.
	assign sr2_num = (opcode == lc3b_pkg::op_str) ? if_id.ir[11:9] : if_id.ir[2:0];

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = lc3b_pkg::alu_pass;
		ctrl.dest   = if_id.ir[11:9];
		if (if_id.valid) begin
			case (opcode)
				lc3b_pkg::op_add: begin
					ctrl.alu_op       = lc3b_pkg::alu_add;
					ctrl.imm_sel      = if_id.ir[5];
					ctrl.load_regfile = 1'b1;
				end
				lc3b_pkg::op_and: begin
					ctrl.alu_op       = lc3b_pkg::alu_and;
					ctrl.imm_sel      = if_id.ir[5];
					ctrl.load_regfile = 1'b1;
				end
				lc3b_pkg::op_not: begin
					ctrl.alu_op       = lc3b_pkg::alu_not;
					ctrl.load_regfile = 1'b1;
				end
				lc3b_pkg::op_ldr: begin
					ctrl.addr_sel     = 1'b1;
					ctrl.mem_read     = 1'b1;
					ctrl.load_regfile = 1'b1;
				end
				lc3b_pkg::op_str: begin
					ctrl.addr_sel  = 1'b1;
					ctrl.mem_write = 1'b1;
				end
				lc3b_pkg::op_br: ;  // Treated as a NOP.
				default: ;          // Unsupported opcodes retire as bubbles.
			endcase
		end
	end

	regfile i_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.wb     (wb),
		.rd_a   (sr1_num),
		.rd_b   (sr2_num),
		.a      (sr1_val),
		.b      (sr2_val)
	);

	assign id_ex.valid = if_id.valid;
	assign id_ex.pc    = if_id.pc;
	assign id_ex.ir    = if_id.ir;
	assign id_ex.ctrl  = ctrl;
	assign id_ex.sr1   = sr1_val;
	assign id_ex.sr2   = sr2_val;

endmodule : instruction_decode

/* rtl/execution_module.sv */
`timescale 1ns/1ps

module execution_module (
	input  lc3b_pkg::id_ex_t  id_ex,
	output lc3b_pkg::ex_mem_t ex_mem
);

	lc3b_pkg::lc3b_word imm5;
	lc3b_pkg::lc3b_word offset6;
	lc3b_pkg::lc3b_word operand_b;
	lc3b_pkg::lc3b_word alu_out;
	lc3b_pkg::lc3b_word addr_out;

	assign imm5    = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};
	assign offset6 = {{9{id_ex.ir[5]}}, id_ex.ir[5:0], 1'b0};  // Word offset in bytes.

	assign operand_b = id_ex.ctrl.imm_sel ? imm5 : id_ex.sr2;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			lc3b_pkg::alu_add: begin
				alu_out = id_ex.sr1 + operand_b;
			end
			lc3b_pkg::alu_and: begin
				alu_out = id_ex.sr1 & operand_b;
			end
			lc3b_pkg::alu_not: begin
				alu_out = ~id_ex.sr1;
			end
			lc3b_pkg::alu_pass: begin
				alu_out = id_ex.sr1;
			end
			default: begin
				alu_out = id_ex.sr1;
			end
		endcase
	end

	// Base plus offset for LDR and STR.
	assign addr_out = id_ex.sr1 + offset6;

	assign ex_mem.valid      = id_ex.valid;
	assign ex_mem.pc         = id_ex.pc;
	assign ex_mem.ir         = id_ex.ir;
	assign ex_mem.ctrl       = id_ex.ctrl;
	assign ex_mem.alu        = id_ex.ctrl.addr_sel ? addr_out : alu_out;
	assign ex_mem.store_data = id_ex.sr2;

endmodule : execution_module

/* rtl/memory_module.sv */
`timescale 1ns/1ps

module memory_module (
	input  lc3b_pkg::ex_mem_t  ex_mem,
	input  lc3b_pkg::lc3b_word mem_rdata,
	output lc3b_pkg::lc3b_word mem_addr,
	output logic               mem_read,
	output logic               mem_write,
	output lc3b_pkg::lc3b_word mem_wdata,
	output lc3b_pkg::wb_t      wb_out
);

	// Single-cycle strobes, only for a real instruction.
	assign mem_read  = ex_mem.valid & ex_mem.ctrl.mem_read;
	assign mem_write = ex_mem.valid & ex_mem.ctrl.mem_write;

	assign mem_addr  = ex_mem.alu;         // Effective address from execute.
	assign mem_wdata = ex_mem.store_data;

	assign wb_out.valid = ex_mem.valid;
	assign wb_out.pc    = ex_mem.pc;
	assign wb_out.ir    = ex_mem.ir;
	assign wb_out.ctrl  = ex_mem.ctrl;
	assign wb_out.alu   = ex_mem.alu;

	// MDR is latched by the writeback stage register.
	// Non-loads carry zero so the retire record stays clean.
	assign wb_out.mdr = mem_read ? mem_rdata : '0;

endmodule : memory_module

/* rtl/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath (
	input  logic               clk,
	input  logic               arst_n,
	output lc3b_pkg::lc3b_word mem_addr1,
	output logic               mem_read1,
	input  lc3b_pkg::lc3b_word mem_rdata1,
	output lc3b_pkg::lc3b_word mem_addr2,
	output logic               mem_read2,
	output logic               mem_write2,
	output lc3b_pkg::lc3b_word mem_wdata2,
	input  lc3b_pkg::lc3b_word mem_rdata2,
	output lc3b_pkg::wb_t      retire
);

	lc3b_pkg::lc3b_word pc;
	logic               fetch_en;
	lc3b_pkg::if_id_t   if_d;
	lc3b_pkg::if_id_t   if_q;
	lc3b_pkg::id_ex_t   id_d;
	lc3b_pkg::id_ex_t   id_q;
	lc3b_pkg::ex_mem_t  ex_d;
	lc3b_pkg::ex_mem_t  ex_q;
	lc3b_pkg::wb_t      mem_d;
	lc3b_pkg::wb_t      wb_q;

	instruction_fetch i_fetch (
		.clk      (clk),
		.arst_n   (arst_n),
		.pc       (pc),
		.fetch_en (fetch_en)
	);

	assign mem_addr1 = pc;
	assign mem_read1 = fetch_en;

	// Instruction word returns in the same cycle.
	assign if_d.valid = fetch_en;
	assign if_d.pc    = pc;
	assign if_d.ir    = mem_rdata1;

	pipe_latch #(.payload_t(lc3b_pkg::if_id_t)) i_if_id_latch (
		.clk (clk), .arst_n (arst_n), .d (if_d), .q (if_q)
	);

	instruction_decode i_decode (
		.clk    (clk),
		.arst_n (arst_n),
		.if_id  (if_q),
		.wb     (wb_q),    // Register write from writeback.
		.id_ex  (id_d)
	);

	pipe_latch #(.payload_t(lc3b_pkg::id_ex_t)) i_id_ex_latch (
		.clk (clk), .arst_n (arst_n), .d (id_d), .q (id_q)
	);

	execution_module i_execute (
		.id_ex  (id_q),
		.ex_mem (ex_d)
	);

	pipe_latch #(.payload_t(lc3b_pkg::ex_mem_t)) i_ex_mem_latch (
		.clk (clk), .arst_n (arst_n), .d (ex_d), .q (ex_q)
	);

	memory_module i_memory (
		.ex_mem    (ex_q),
		.mem_rdata (mem_rdata2),
		.mem_addr  (mem_addr2),
		.mem_read  (mem_read2),
		.mem_write (mem_write2),
		.mem_wdata (mem_wdata2),
		.wb_out    (mem_d)
	);

	pipe_latch #(.payload_t(lc3b_pkg::wb_t)) i_mem_wb_latch (
		.clk (clk), .arst_n (arst_n), .d (mem_d), .q (wb_q)
	);

	assign retire = wb_q;  // Instruction leaving writeback.

endmodule : cpu_datapath

/* bench/tb_cpu_datapath.sv */
`timescale 1ns/1ps

module tb_cpu_datapath;

	localparam int prog_len   = 64;
	localparam int max_cycles = 300;

	logic               clk = 1'b0;
	logic               arst_n;
	lc3b_pkg::lc3b_word mem_addr1;
	logic               mem_read1;
	lc3b_pkg::lc3b_word mem_rdata1;
	lc3b_pkg::lc3b_word mem_addr2;
	logic               mem_read2;
	logic               mem_write2;
	lc3b_pkg::lc3b_word mem_wdata2;
	lc3b_pkg::lc3b_word mem_rdata2;
	lc3b_pkg::wb_t      retire;

	logic [31:0]        lcg_state;
	lc3b_pkg::lc3b_word imem [256];
	lc3b_pkg::lc3b_word dmem [256];
	lc3b_pkg::lc3b_word model_mem [256];
	lc3b_pkg::lc3b_word model_regs [8];
	lc3b_pkg::lc3b_reg  prog_dest [prog_len];  // Field ir[11:9] of each instruction.
	int                 fetch_cycle [256];

	lc3b_pkg::wb_t      exp_retire [$];
	lc3b_pkg::lc3b_word exp_load_addr [$];
	lc3b_pkg::lc3b_word exp_store_addr [$];
	lc3b_pkg::lc3b_word exp_store_data [$];

	int                 model_stores;
	int                 store_count;
	int                 retire_count;
	int                 cycle_count;
	int                 first_fetch_cycle;
	logic               fetch_started;
	lc3b_pkg::lc3b_word expected_pc;

	cpu_datapath i_cpu_datapath (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_addr1  (mem_addr1),
		.mem_read1  (mem_read1),
		.mem_rdata1 (mem_rdata1),
		.mem_addr2  (mem_addr2),
		.mem_read2  (mem_read2),
		.mem_write2 (mem_write2),
		.mem_wdata2 (mem_wdata2),
		.mem_rdata2 (mem_rdata2),
		.retire     (retire)
	);

	always #20 clk = ~clk;

	// Both memories answer in the same cycle. Byte addresses map to words.
	assign mem_rdata1 = imem[mem_addr1[8:1]];
	assign mem_rdata2 = dmem[mem_addr2[8:1]];

	always @(posedge clk) begin
		if (mem_write2) begin
			dmem[mem_addr2[8:1]] <= mem_wdata2;
		end
	end

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Source register that avoids the targets of the two previous instructions.
	function automatic lc3b_pkg::lc3b_reg pick_src(input int idx);
		logic [15:0]       rnd;
		lc3b_pkg::lc3b_reg r;
		rnd = next_random();
		r   = rnd[2:0];
		if (rnd[3]) begin
			r = prog_dest[idx - 3];  // Producer three back is read through the write-through path.
		end
		for (int n = 0; n < 3; n++) begin
			if (r == prog_dest[idx - 1] || r == prog_dest[idx - 2]) begin
				r = r + 3'd1;
			end
		end
		return r;
	endfunction

	task automatic gen_program();
		logic [15:0]       rnd;
		logic [15:0]       fld;
		lc3b_pkg::lc3b_reg dr;
		lc3b_pkg::lc3b_reg s1;
		lc3b_pkg::lc3b_reg s2;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 16'h0000;  // BR with no condition bits.
		end
		for (int i = 0; i < prog_len; i++) begin
			rnd = next_random();
			fld = next_random();
			if (i < 8) begin
				dr      = 3'(i);
				imem[i] = {lc3b_pkg::op_and, dr, dr, 1'b1, 5'b00000};  // Clear.
			end else if (i < 16) begin
				dr      = 3'(i - 8);
				imem[i] = {lc3b_pkg::op_add, dr, dr, 1'b1, fld[4:0]};  // Small seed value.
			end else begin
				dr = rnd[5:3];
				s1 = pick_src(i);
				s2 = pick_src(i);
				case (rnd[2:0])
					3'd0: imem[i] = {lc3b_pkg::op_add, dr, s1, 3'b000, s2};
					3'd1: imem[i] = {lc3b_pkg::op_add, dr, s1, 1'b1, fld[4:0]};
					3'd2: imem[i] = {lc3b_pkg::op_and, dr, s1, 3'b000, s2};
					3'd3: imem[i] = {lc3b_pkg::op_and, dr, s1, 1'b1, fld[4:0]};
					3'd4: imem[i] = {lc3b_pkg::op_not, dr, s1, 6'b111111};
					3'd5, 3'd6: imem[i] = {lc3b_pkg::op_ldr, dr, s1, fld[5:0]};
					default: imem[i] = {lc3b_pkg::op_str, s2, s1, fld[5:0]};
				endcase
			end
			prog_dest[i] = imem[i][11:9];
		end
	endtask

	task automatic fill_data_memory();
		lc3b_pkg::lc3b_word word;
		for (int a = 0; a < 256; a++) begin
			word         = next_random();
			dmem[a]      <= word;
			model_mem[a] = word;
		end
	endtask

	// In-order interpreter of the program.
	task automatic run_model();
		lc3b_pkg::lc3b_word ir;
		lc3b_pkg::lc3b_word src_a;
		lc3b_pkg::lc3b_word src_b;
		lc3b_pkg::lc3b_word addr;
		lc3b_pkg::wb_t      rec;
		for (int r = 0; r < 8; r++) begin
			model_regs[r] = '0;
		end
		for (int i = 0; i < prog_len; i++) begin
			ir        = imem[i];
			src_a     = model_regs[ir[8:6]];
			src_b     = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
			addr      = src_a + {{9{ir[5]}}, ir[5:0], 1'b0};
			rec       = '0;
			rec.valid = 1'b1;
			rec.pc    = 16'(i * 2);
			rec.ir    = ir;
			rec.ctrl.load_regfile = (ir[15:12] != lc3b_pkg::op_str);
			case (ir[15:12])
				lc3b_pkg::op_add: rec.alu = src_a + src_b;
				lc3b_pkg::op_and: rec.alu = src_a & src_b;
				lc3b_pkg::op_not: rec.alu = ~src_a;
				lc3b_pkg::op_ldr: begin
					rec.alu = addr;
					rec.mdr = model_mem[addr[8:1]];
					exp_load_addr.push_back(addr);
				end
				default: begin  // STR.
					rec.alu = addr;
					exp_store_addr.push_back(addr);
					exp_store_data.push_back(model_regs[ir[11:9]]);
					model_mem[addr[8:1]] = model_regs[ir[11:9]];
					model_stores++;
				end
			endcase
			if (ir[15:12] == lc3b_pkg::op_ldr) begin
				model_regs[ir[11:9]] = rec.mdr;
			end else if (ir[15:12] != lc3b_pkg::op_str) begin
				model_regs[ir[11:9]] = rec.alu;
			end
			exp_retire.push_back(rec);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input lc3b_pkg::lc3b_word got,
			input lc3b_pkg::lc3b_word exp);
		if (got !== exp) begin
			report_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_retire(input lc3b_pkg::wb_t got, input lc3b_pkg::wb_t exp);
		check_word("retire.pc", got.pc, exp.pc);
		check_word("retire.ir", got.ir, exp.ir);
		check_flag("retire.ctrl.load_regfile", got.ctrl.load_regfile,
			exp.ctrl.load_regfile);
		check_word("retire.alu", got.alu, exp.alu);  // ALU result or address.
		if (exp.ir[15:12] == lc3b_pkg::op_ldr) begin
			check_word("retire.mdr", got.mdr, exp.mdr);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they settle.
	always @(negedge clk) begin : monitor
		lc3b_pkg::wb_t      exp_rec;
		lc3b_pkg::lc3b_word exp_addr;
		lc3b_pkg::lc3b_word exp_data;
		cycle_count++;
		if (!arst_n) begin
			check_flag("mem_read1", mem_read1, 1'b0);
			check_flag("mem_read2", mem_read2, 1'b0);
			check_flag("mem_write2", mem_write2, 1'b0);
			check_flag("retire.valid", retire.valid, 1'b0);
		end else begin
			if (!fetch_started || cycle_count < first_fetch_cycle + 3) begin
				check_flag("mem_read2", mem_read2, 1'b0);
				check_flag("mem_write2", mem_write2, 1'b0);
			end
			if (!fetch_started || cycle_count < first_fetch_cycle + 4) begin
				check_flag("retire.valid", retire.valid, 1'b0);
			end
			check_flag("mem_read1", mem_read1, 1'b1);  // Fetch never pauses.
			if (mem_read1) begin
				check_word("mem_addr1", mem_addr1, expected_pc);
				if (!fetch_started) begin
					fetch_started     = 1'b1;
					first_fetch_cycle = cycle_count;
				end
				fetch_cycle[mem_addr1[8:1]] = cycle_count;
				expected_pc = expected_pc + 16'd2;
			end
			if (mem_read2) begin
				if (exp_load_addr.size() == 0) begin
					report_failure("A load strobe appeared with no load left in the program.");
				end
				exp_addr = exp_load_addr.pop_front();
				check_word("mem_addr2", mem_addr2, exp_addr);
			end
			if (mem_write2) begin
				if (exp_store_addr.size() == 0) begin
					report_failure("A store strobe appeared with no store left in the program.");
				end
				exp_addr = exp_store_addr.pop_front();
				exp_data = exp_store_data.pop_front();
				check_word("mem_addr2", mem_addr2, exp_addr);
				check_word("mem_wdata2", mem_wdata2, exp_data);
				store_count++;
			end
			if (retire.valid) begin
				if (exp_retire.size() == 0) begin
					check_word("retire.ir", retire.ir, 16'h0000);  // Trailing NOPs only.
				end else begin
					exp_rec = exp_retire.pop_front();
					check_retire(retire, exp_rec);
					if (cycle_count != fetch_cycle[retire.pc[8:1]] + 4) begin
						report_failure($sformatf(
							"Instruction at pc %h did not retire 4 cycles after its fetch.",
							retire.pc));
					end
					retire_count++;
				end
			end
		end
	end

	initial begin
		int wait_cycles;
		arst_n            = 1'b0;
		lcg_state         = 32'hc392;
		model_stores      = 0;
		store_count       = 0;
		retire_count      = 0;
		cycle_count       = 0;
		first_fetch_cycle = 0;
		fetch_started     = 1'b0;
		expected_pc       = lc3b_pkg::pc_reset;
		gen_program();
		fill_data_memory();
		run_model();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		wait_cycles = 0;
		while (retire_count < prog_len && wait_cycles < max_cycles) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (retire_count < prog_len) begin
			report_failure("Timeout: the program did not retire within the cycle limit.");
		end else if (store_count != model_stores || exp_load_addr.size() != 0) begin
			report_failure("The number of loads or stores seen differs from the model.");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule : tb_cpu_datapath

/* filelist.f */
common/lc3b_pkg.sv
rtl/pipe_latch.sv
fetch/instruction_fetch.sv
decode/regfile.sv
decode/instruction_decode.sv
rtl/execution_module.sv
rtl/memory_module.sv
rtl/cpu_datapath.sv
bench/tb_cpu_datapath.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_cpu_datapath -f filelist.f -o tb_cpu_datapath

out=$(./obj_dir/tb_cpu_datapath) || true
echo "$out"

# The run passes only if the pass message was printed.
echo "$out" | grep -q "STATUS: PASS"
